/* src/draw_pkg.sv */
package draw_pkg;

	// pixel grid is 160x120
	typedef logic [7:0] x_t; // column 0..159
	typedef logic [6:0] y_t; // row 0..119

	// one bit per channel, r g b
	typedef logic [2:0] colour_t;

	localparam colour_t colour_black  = 3'b000;
	localparam colour_t colour_white  = 3'b111;
	localparam colour_t colour_blue   = 3'b001;
	localparam colour_t colour_yellow = 3'b110;
	localparam colour_t colour_red    = 3'b100; // selector outline

	// box is 26x26, offsets 0..box_last on each axis
	localparam int box_last = 25;

	// inner square window, inclusive on both ends
	localparam int inner_lo = 5;
	localparam int inner_hi = 19;

endpackage

/* src/board_pkg.sv */
package board_pkg;

	typedef enum logic [1:0] {
		piece_none,
		piece_blue,
		piece_yellow
	} piece_t;

	// one board square
	typedef struct packed {
		logic   shade; // 1 = white square
		piece_t piece;
	} cell_t;

	typedef logic [3:0] cell_idx_t; // 4*row + col

	typedef enum logic [1:0] {
		dir_up,
		dir_down,
		dir_left,
		dir_right
	} dir_t;

	localparam int board_dim = 4; // cells per side
	localparam int num_cells = board_dim * board_dim;

	// pixel origin of cell 0, and spacing between neighbours
	localparam int origin_x0  = 30;
	localparam int origin_y0  = 10;
	localparam int cell_pitch = 25;

	// white where row + col is odd, yellow on row 0, blue on row 3
	localparam cell_t initial_board [num_cells] = '{
		'{1'b0, piece_yellow}, '{1'b1, piece_yellow}, '{1'b0, piece_yellow}, '{1'b1, piece_yellow},
		'{1'b1, piece_none}, '{1'b0, piece_none}, '{1'b1, piece_none}, '{1'b0, piece_none},
		'{1'b0, piece_none}, '{1'b1, piece_none}, '{1'b0, piece_none}, '{1'b1, piece_none},
		'{1'b1, piece_blue}, '{1'b0, piece_blue}, '{1'b1, piece_blue}, '{1'b0, piece_blue}
	};

	// top left pixel of a cell, column from the low index bits
	function automatic draw_pkg::x_t cell_x(cell_idx_t idx);
		return draw_pkg::x_t'(origin_x0 + cell_pitch * int'(idx[1:0]));
	endfunction

	function automatic draw_pkg::y_t cell_y(cell_idx_t idx);
		return draw_pkg::y_t'(origin_y0 + cell_pitch * int'(idx[3:2])); // row bits
	endfunction

	// inner square colour, falls back to the square shade when empty
	function automatic draw_pkg::colour_t piece_colour(cell_t c);
		case (c.piece)
			piece_blue:   return draw_pkg::colour_blue;
			piece_yellow: return draw_pkg::colour_yellow;
			default:      return c.shade ? draw_pkg::colour_white : draw_pkg::colour_black;
		endcase
	endfunction

endpackage

/* src/board_controller.sv */
`timescale 1ns/1ns
module board_controller (
	input  logic                  clk,
	input  logic                  reset,
	input  board_pkg::cell_idx_t  selector,
	input  logic [3:0]            direction, // one-hot: up, down, left, right
	input  logic                  done_p,
	input  logic                  done_s,
	output logic                  load_p,
	output logic                  load_s,
	output logic                  sel_phase, // 0 grid, 1 selector
	output draw_pkg::x_t          start_x,
	output draw_pkg::y_t          start_y,
	output draw_pkg::colour_t     rim_colour,
	output draw_pkg::colour_t     inner_colour,
	output logic                  board_drawn
);

	typedef enum logic [2:0] {
		st_load_cell,
		st_wait_cell,
		st_load_sel,
		st_wait_sel,
		st_idle,
		st_wait_release,
		st_move
	} state_t;

	state_t               state;
	board_pkg::cell_t     cells [board_pkg::num_cells]; // board contents
	board_pkg::cell_idx_t idx; // cell being drawn
	board_pkg::cell_idx_t sel_q; // selector seen at last redraw
	board_pkg::dir_t      dir_dec;
	board_pkg::dir_t      dir_q;
	board_pkg::cell_idx_t tgt; // cell the move lands on
	logic                 tgt_ok; // target still on the board
	logic [1:0]           row;
	logic [1:0]           col;

	// more than one button (or none) counts as up
	always_comb begin
		case (direction)
			4'b0100: dir_dec = board_pkg::dir_down;
			4'b0010: dir_dec = board_pkg::dir_left;
			4'b0001: dir_dec = board_pkg::dir_right;
			default: dir_dec = board_pkg::dir_up;
		endcase
	end

	assign row = sel_q[3:2];
	assign col = sel_q[1:0];

	// neighbour in the latched direction
	always_comb begin
		tgt    = sel_q;
		tgt_ok = 1'b0;
		case (dir_q)
			board_pkg::dir_up: begin
				tgt    = sel_q - 4'd4;
				tgt_ok = (row != 2'd0);
			end
			board_pkg::dir_down: begin
				tgt    = sel_q + 4'd4;
				tgt_ok = (int'(row) < board_pkg::board_dim - 1);
			end
			board_pkg::dir_left: begin
				tgt    = sel_q - 4'd1;
				tgt_ok = (col != 2'd0);
			end
			default: begin
				tgt    = sel_q + 4'd1;
				tgt_ok = (int'(col) < board_pkg::board_dim - 1);
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state       <= st_load_cell; // reset triggers a full redraw
			cells       <= board_pkg::initial_board;
			idx         <= '0;
			sel_q       <= selector;
			dir_q       <= board_pkg::dir_up;
			load_p      <= 1'b0;
			load_s      <= 1'b0;
			sel_phase   <= 1'b0;
			board_drawn <= 1'b0;
		end else begin
			load_p      <= 1'b0; // pulses only
			load_s      <= 1'b0;
			board_drawn <= 1'b0;
			case (state)
				st_load_cell: begin
					sel_phase    <= 1'b0;
					load_p       <= 1'b1;
					start_x      <= board_pkg::cell_x(idx);
					start_y      <= board_pkg::cell_y(idx);
					rim_colour   <= cells[idx].shade ? draw_pkg::colour_white
						: draw_pkg::colour_black;
					inner_colour <= board_pkg::piece_colour(cells[idx]);
					state        <= st_wait_cell;
				end
				st_wait_cell: if (done_p) begin
					if (int'(idx) == board_pkg::num_cells - 1) begin
						state <= st_load_sel;
					end else begin
						idx   <= idx + 4'd1;
						state <= st_load_cell;
					end
				end
				st_load_sel: begin
					sel_phase <= 1'b1; // arbiter follows the selector drawer now
					load_s    <= 1'b1;
					start_x   <= board_pkg::cell_x(sel_q);
					start_y   <= board_pkg::cell_y(sel_q);
					state     <= st_wait_sel;
				end
				st_wait_sel: if (done_s) begin
					board_drawn <= 1'b1; // one cycle after done_s, matches arbiter delay
					state       <= st_idle;
				end
				st_idle: begin
					if (selector != sel_q) begin
						sel_q <= selector;
						idx   <= '0;
						state <= st_load_cell;
					end else if (|direction) begin
						dir_q <= dir_dec;
						state <= st_wait_release;
					end
				end
				st_wait_release: begin
					if (|direction)
						dir_q <= dir_dec; // keep last held pattern
					else
						state <= st_move;
				end
				st_move: begin
					// empty source or off-board target leaves the board alone
					if (tgt_ok && cells[sel_q].piece != board_pkg::piece_none) begin
						cells[tgt].piece   <= cells[sel_q].piece; // overwrites any piece there
						cells[sel_q].piece <= board_pkg::piece_none;
					end
					idx   <= '0;
					state <= st_load_cell;
				end
				default: state <= st_idle;
			endcase
		end
	end

endmodule

/* src/cell_drawer.sv */
`timescale 1ns/1ns
module cell_drawer (
	input  logic              clk,
	input  logic              reset,
	input  logic              load_p,
	input  draw_pkg::x_t      start_x,
	input  draw_pkg::y_t      start_y,
	input  draw_pkg::colour_t rim_colour,
	input  draw_pkg::colour_t inner_colour,
	output draw_pkg::x_t      x,
	output draw_pkg::y_t      y,
	output draw_pkg::colour_t colour,
	output logic              draw,
	output logic              done_p
);

	logic [4:0] ox; // column offset in the box
	logic [4:0] oy; // row offset
	logic       busy;
	logic       in_x;
	logic       in_y;

	// raster scan, row by row, one pixel per cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			busy   <= 1'b0;
			done_p <= 1'b0;
			ox     <= '0;
			oy     <= '0;
		end else begin
			done_p <= 1'b0;
			if (load_p) begin
				busy <= 1'b1;
				ox   <= '0;
				oy   <= '0;
			end else if (busy) begin
				if (ox == 5'(draw_pkg::box_last)) begin
					ox <= '0; // wrap to next row
					if (oy == 5'(draw_pkg::box_last)) begin
						busy   <= 1'b0; // 676th pixel just went out
						done_p <= 1'b1;
					end else begin
						oy <= oy + 5'd1;
					end
				end else begin
					ox <= ox + 5'd1;
				end
			end
		end
	end

	// inner square window on both axes
	assign in_x = (ox >= 5'(draw_pkg::inner_lo)) && (ox <= 5'(draw_pkg::inner_hi));
	assign in_y = (oy >= 5'(draw_pkg::inner_lo)) && (oy <= 5'(draw_pkg::inner_hi));

	assign x      = start_x + draw_pkg::x_t'(ox);
	assign y      = start_y + draw_pkg::y_t'(oy);
	assign colour = (in_x && in_y) ? inner_colour : rim_colour;
	assign draw   = busy;

endmodule

/* src/selector_drawer.sv */
`timescale 1ns/1ns
module selector_drawer (
	input  logic              clk,
	input  logic              reset,
	input  logic              load_s,
	input  draw_pkg::x_t      start_x,
	input  draw_pkg::y_t      start_y,
	output draw_pkg::x_t      x,
	output draw_pkg::y_t      y,
	output draw_pkg::colour_t colour,
	output logic              draw,
	output logic              done_s
);

	typedef enum logic [2:0] {
		edge_idle,
		edge_top,
		edge_right,
		edge_bottom,
		edge_left
	} edge_t;

	edge_t      state;
	logic [4:0] step; // position along current edge, 0..24
	logic [4:0] ox;
	logic [4:0] oy;
	logic       edge_end;

	assign edge_end = (step == 5'(draw_pkg::box_last - 1));

	// clockwise from the top left corner, corners drawn once each
	always_ff @(posedge clk) begin
		if (reset) begin
			state  <= edge_idle;
			step   <= '0;
			ox     <= '0;
			oy     <= '0;
			done_s <= 1'b0;
		end else begin
			done_s <= 1'b0;
			if (load_s) begin
				state <= edge_top;
				step  <= '0;
				ox    <= '0;
				oy    <= '0;
			end else if (state != edge_idle) begin
				step <= edge_end ? 5'd0 : step + 5'd1;
				case (state)
					edge_top:    ox <= ox + 5'd1; // heading right
					edge_right:  oy <= oy + 5'd1; // heading down
					edge_bottom: ox <= ox - 5'd1;
					default:     oy <= oy - 5'd1; // back up the left side
				endcase
				if (edge_end) begin
					case (state)
						edge_top:    state <= edge_right;
						edge_right:  state <= edge_bottom;
						edge_bottom: state <= edge_left;
						default: begin
							state  <= edge_idle; // 100 pixels out
							done_s <= 1'b1;
						end
					endcase
				end
			end
		end
	end

	assign x      = start_x + draw_pkg::x_t'(ox);
	assign y      = start_y + draw_pkg::y_t'(oy);
	assign colour = draw_pkg::colour_red;
	assign draw   = (state != edge_idle);

endmodule

/* src/pixel_arbiter.sv */
`timescale 1ns/1ns
module pixel_arbiter (
	input  logic              clk,
	input  logic              reset,
	input  logic              sel_phase, // 1 picks the selector drawer
	input  draw_pkg::x_t      grid_x,
	input  draw_pkg::y_t      grid_y,
	input  draw_pkg::colour_t grid_colour,
	input  logic              grid_draw,
	input  draw_pkg::x_t      sel_x,
	input  draw_pkg::y_t      sel_y,
	input  draw_pkg::colour_t sel_colour,
	input  logic              sel_draw,
	output draw_pkg::x_t      pix_x,
	output draw_pkg::y_t      pix_y,
	output draw_pkg::colour_t pix_colour,
	output logic              plot
);

	// pixel payload, only meaningful alongside plot
	always_ff @(posedge clk) begin
		pix_x      <= sel_phase ? sel_x : grid_x;
		pix_y      <= sel_phase ? sel_y : grid_y;
		pix_colour <= sel_phase ? sel_colour : grid_colour;
	end

	always_ff @(posedge clk) begin
		if (reset)
			plot <= 1'b0;
		else
			plot <= sel_phase ? sel_draw : grid_draw; // strobe from active drawer only
	end

endmodule

/* src/castle_board_top.sv */
`timescale 1ns/1ns
module castle_board_top (
	input  logic                 clk,
	input  logic                 reset,
	input  board_pkg::cell_idx_t selector,
	input  logic [3:0]           direction,
	output draw_pkg::x_t         pix_x,
	output draw_pkg::y_t         pix_y,
	output draw_pkg::colour_t    pix_colour,
	output logic                 plot,
	output logic                 board_drawn
);

	logic              load_p, load_s, done_p, done_s, sel_phase;
	draw_pkg::x_t      start_x, grid_x, sel_x;
	draw_pkg::y_t      start_y, grid_y, sel_y;
	draw_pkg::colour_t rim_colour, inner_colour, grid_colour, sel_colour;
	logic              grid_draw, sel_draw;

	board_controller u_ctrl (
		.clk, .reset, .selector, .direction, .done_p, .done_s,
		.load_p, .load_s, .sel_phase, .start_x, .start_y,
		.rim_colour, .inner_colour, .board_drawn
	);

	// both drawers share the controller's start point
	cell_drawer u_cell (
		.clk, .reset, .load_p, .start_x, .start_y, .rim_colour, .inner_colour,
		.x(grid_x), .y(grid_y), .colour(grid_colour), .draw(grid_draw), .done_p
	);

	selector_drawer u_sel (
		.clk, .reset, .load_s, .start_x, .start_y,
		.x(sel_x), .y(sel_y), .colour(sel_colour), .draw(sel_draw), .done_s
	);

	pixel_arbiter u_arb (
		.clk, .reset, .sel_phase,
		.grid_x, .grid_y, .grid_colour, .grid_draw,
		.sel_x, .sel_y, .sel_colour, .sel_draw,
		.pix_x, .pix_y, .pix_colour, .plot
	);

endmodule

/* tb/board_checker.sv */
`timescale 1ns/1ns
module board_checker (
	input  logic       clk,
	input  logic       reset,
	input  logic [3:0] selector,
	input  logic [3:0] direction,
	input  logic [7:0] pix_x,
	input  logic [6:0] pix_y,
	input  logic [2:0] pix_colour,
	input  logic       plot,
	input  logic       board_drawn,
	output int         value_errors,
	output int         other_errors,
	output int         redraws
);

	typedef logic [15:0][1:0] pieces_t; // piece code per cell index
	localparam logic [1:0] p_none   = 2'd0;
	localparam logic [1:0] p_blue   = 2'd1;
	localparam logic [1:0] p_yellow = 2'd2;
	localparam int frame_plots = 16 * 676 + 100; // sixteen boxes then the outline

	logic [2:0] fb [0:119][0:159]; // painted from the plot stream
	pieces_t    board_ref;
	logic [3:0] sel_ref;
	logic [3:0] dir_held; // last pattern seen while a button is down
	logic       reset_q = 1'b0;
	logic       quiet   = 1'b0; // board drawn, no stimulus since
	int         plots   = 0;
	int         n_value = 0;
	int         n_other = 0;
	int         n_drawn = 0;

	assign value_errors = n_value;
	assign other_errors = n_other;
	assign redraws      = n_drawn;

	// yellow on the top row, blue on the bottom row
	function automatic pieces_t start_board();
		pieces_t b;
		for (int i = 0; i < 16; i++)
			b[i] = (i < 4) ? p_yellow : ((i >= 12) ? p_blue : p_none);
		return b;
	endfunction

	// reference move, one cell in the decoded direction if it stays on the board
	function automatic pieces_t apply_move(pieces_t b, logic [3:0] sel, logic [3:0] dirs);
		int trow;
		int tcol;
		trow = int'(sel[3:2]);
		tcol = int'(sel[1:0]);
		case (dirs)
			4'b0100: trow = trow + 1; // down
			4'b0010: tcol = tcol - 1; // left
			4'b0001: tcol = tcol + 1; // right
			default: trow = trow - 1; // up, also for any odd pattern
		endcase
		if (trow >= 0 && trow < 4 && tcol >= 0 && tcol < 4 && b[sel] != p_none) begin
			b[trow * 4 + tcol] = b[sel]; // whatever sat there is lost
			b[sel] = p_none;
		end
		return b;
	endfunction

	function automatic logic [2:0] shade_colour(int idx);
		return ((idx / 4 + idx % 4) % 2 == 1) ? 3'b111 : 3'b000; // odd sum is white
	endfunction

	// colour a finished frame should show at one pixel
	function automatic logic [2:0] expected_pixel(pieces_t b, logic [3:0] sel, int px, int py);
		int ox;
		int oy;
		logic [2:0] c;
		c  = 3'b000;
		ox = px - (30 + 25 * int'(sel[1:0]));
		oy = py - (10 + 25 * int'(sel[3:2]));
		if (ox >= 0 && ox <= 25 && oy >= 0 && oy <= 25 && (ox == 0 || ox == 25 || oy == 0 || oy == 25))
			return 3'b100; // outline goes on last
		for (int idx = 0; idx < 16; idx++) begin
			ox = px - (30 + 25 * (idx % 4));
			oy = py - (10 + 25 * (idx / 4));
			if (ox >= 0 && ox <= 25 && oy >= 0 && oy <= 25) begin
				if (ox >= 5 && ox <= 19 && oy >= 5 && oy <= 19 && b[idx] != p_none)
					c = (b[idx] == p_blue) ? 3'b001 : 3'b110;
				else
					c = shade_colour(idx); // rim, or inner square of an empty cell
			end // later cells cover shared edges
		end
		return c;
	endfunction

	task automatic check_frame();
		int shown;
		logic [2:0] exp_c;
		shown = 0;
		for (int py = 10; py <= 110; py++) begin
			for (int px = 30; px <= 130; px++) begin
				exp_c = expected_pixel(board_ref, sel_ref, px, py);
				if (fb[py][px] !== exp_c) begin
					n_value++;
					if (shown < 10)
						$display("ERROR pix_colour at x=%h y=%h: expected %h got %h",
							8'(px), 7'(py), exp_c, fb[py][px]);
					shown++;
				end
			end
		end
	endtask

	always @(posedge clk) begin
		if (reset) begin
			if (reset_q && plot !== 1'b0) begin
				n_other++;
				$display("plot was not held low during reset");
			end
			board_ref = start_board();
			sel_ref   = selector; // latched by the controller in reset
			dir_held  = 4'b0000;
			plots     = 0;
			quiet     = 1'b0;
		end else begin
			if (plot !== 1'b0 && plot !== 1'b1) begin
				n_other++;
				$display("plot is unknown after reset");
			end else if (plot) begin
				plots++;
				if (quiet) begin
					n_other++;
					$display("plot went high while the board was idle");
				end
				if (pix_x < 8'd30 || pix_x > 8'd130 || pix_y < 7'd10 || pix_y > 7'd110) begin
					n_other++;
					$display("a pixel was plotted outside the board area");
				end else begin
					fb[pix_y][pix_x] = pix_colour;
				end
			end
			if (selector != sel_ref) begin
				sel_ref = selector;
				quiet   = 1'b0;
			end
			if (direction != 4'b0000) begin
				dir_held = direction;
				quiet    = 1'b0;
			end else if (dir_held != 4'b0000) begin
				board_ref = apply_move(board_ref, sel_ref, dir_held); // move on release
				dir_held  = 4'b0000;
			end
			if (board_drawn === 1'b1) begin
				n_drawn++;
				if (plots != frame_plots) begin
					n_value++;
					$display("ERROR plot count: expected %h got %h", frame_plots, plots);
				end
				check_frame();
				plots = 0;
				quiet = 1'b1;
			end
		end
		reset_q = reset;
	end

endmodule

/* tb/castle_tb.sv */
`timescale 1ns/1ns
module castle_tb;

	localparam int clk_period    = 10;
	localparam int redraw_cycles = 16 * 678 + 102; // worst case per full board
	localparam int max_redraws   = 12; // reset, 9 directed, 2 random
	localparam int watchdog_ns   = max_redraws * redraw_cycles * 2 * clk_period;

	logic       clk;
	logic       reset;
	logic [3:0] selector;
	logic [3:0] direction; // up, down, left, right
	logic [7:0] pix_x;
	logic [6:0] pix_y;
	logic [2:0] pix_colour;
	logic       plot;
	logic       board_drawn;
	logic [31:0] lcg_state;
	int         value_errors;
	int         other_errors;
	int         redraws;

	castle_board_top dut (
		.clk, .reset, .selector, .direction,
		.pix_x, .pix_y, .pix_colour, .plot, .board_drawn
	);

	board_checker chk (
		.clk, .reset, .selector, .direction,
		.pix_x, .pix_y, .pix_colour, .plot, .board_drawn,
		.value_errors, .other_errors, .redraws
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	function automatic logic [31:0] lcg_next(logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic idle_cycles(int n);
		repeat (n) @(posedge clk);
		#1; // drive just after the edge
	endtask

	task automatic wait_drawn();
		@(posedge clk);
		while (board_drawn !== 1'b1)
			@(posedge clk);
		#1;
	endtask

	task automatic change_selector(logic [3:0] s);
		idle_cycles(4); // quiet gap, plot must stay low
		selector = s;
		wait_drawn();
	endtask

	task automatic press_release(logic [3:0] d);
		idle_cycles(4);
		direction = d;
		idle_cycles(3); // held a few cycles
		direction = 4'b0000;
		wait_drawn();
	endtask

	// either a new selector or a button pattern, each forces one redraw
	task automatic random_step();
		logic [3:0] r;
		lcg_state = lcg_next(lcg_state);
		r = lcg_state[19:16];
		if (lcg_state[20]) begin
			if (r == selector)
				r = r ^ 4'b0001; // must differ to trigger a redraw
			change_selector(r);
		end else begin
			if (r == 4'b0000)
				r = 4'b0010;
			press_release(r); // multi-bit patterns count as up
		end
	endtask

	initial begin
		reset     = 1'b1;
		selector  = 4'd12; // outline starts on a blue piece
		direction = 4'b0000;
		lcg_state = 32'd29171;
		repeat (3) @(posedge clk);
		#1 reset = 1'b0;
		wait_drawn();
		press_release(4'b0100); // off the bottom edge, 12 keeps its piece
		press_release(4'b0001); // blue 12 right onto the blue at 13
		press_release(4'b0001); // cell 12 is empty now, 13 keeps its piece
		change_selector(4'd13);
		press_release(4'b1000); // 13 up to 9
		change_selector(4'd9);
		press_release(4'b0010); // 9 left to 8
		change_selector(4'd8);
		press_release(4'b0100); // 8 down to 12
		repeat (2) random_step();
		idle_cycles(8);
		$display("checks done: %0d redraws, %0d value errors, %0d other errors",
			redraws, value_errors, other_errors);
		if (redraws != max_redraws)
			$display("board_drawn pulsed a different number of times than redraws requested");
		if (value_errors == 0 && other_errors == 0 && redraws == max_redraws) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	// watchdog, scaled from the number of redraws
	initial begin
		#(watchdog_ns);
		$display("watchdog expired before all redraws finished");
		$display("checks done: %0d redraws, %0d value errors, %0d other errors",
			redraws, value_errors, other_errors);
		$display("Test failed");
		$finish;
	end

endmodule

/* src.f */
src/draw_pkg.sv
src/board_pkg.sv
src/board_controller.sv
src/cell_drawer.sv
src/selector_drawer.sv
src/pixel_arbiter.sv
src/castle_board_top.sv
tb/board_checker.sv
tb/castle_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module castle_tb -f src.f -o castle_sim

out=$(./obj_dir/castle_sim)
echo "$out"

if echo "$out" | grep -qx "Test passed"; then
	exit 0
fi
exit 1
